// ==== verilog.f ====
hw/graphPkg.sv
hw/accumPkg.sv
hw/edgeDecode.sv
hw/componentCounter.sv
hw/coeffAccumulator.sv
hw/aggregatingPipeline.sv
tb/aggregatingPipeline_props.sv
tb/tbAggregatingPipeline.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tbAggregatingPipeline
FILELIST  := verilog.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tbAggregatingPipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbAggregatingPipeline;

    import graphPkg::*;
    import accumPkg::*;

    localparam int timeoutCycles = 4000;  // Six batches, 64 items at 8 cycles, with margin.

    logic      clk;
    logic      rstN;
    edgeSetT   sharedTop;
    edgeSetT   bot;
    logic      lastBotOfBatch;
    logic      botValid;
    logic      botReady;
    logic      resultsValid;
    coeffSumT  pcoeffSum;
    itemCountT pcoeffCount;

    edgeSetT     stim [128];
    logic [31:0] rngState = 32'hb3bb_a351;
    int          cycleCount = 0;

    aggregatingPipeline u_aggregatingPipeline (
        .clk            (clk),
        .rstN           (rstN),
        .sharedTop      (sharedTop),
        .bot            (bot),
        .lastBotOfBatch (lastBotOfBatch),
        .botValid       (botValid),
        .botReady       (botReady),
        .resultsValid   (resultsValid),
        .pcoeffSum      (pcoeffSum),
        .pcoeffCount    (pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles waiting for the DUT", cycleCount);
            $display("tests failed");
            $fatal(1, "simulation stopped on timeout");
        end else if (u_aggregatingPipeline.u_props.assertFailures != 0) begin
            $display("An assertion in the bound checker failed");
            $display("tests failed");
            $fatal(1, "simulation stopped on assertion failure");
        end
    end

    // ==============================
    // Stimulus and reference model.
    // ==============================
    function automatic edgeSetT randEdges();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState[30:16];
    endfunction

    // Single edge (a,b), a<b, in lexicographic numbering.
    function automatic edgeSetT edgeBit(int a, int b);
        edgeSetT e;
        int      k;
        e = '0;
        k = 0;
        for (int i = 0; i < numVertices; i++) begin
            for (int j = i + 1; j < numVertices; j++) begin
                if (i == a && j == b) e[k] = 1'b1;
                k++;
            end
        end
        return e;
    endfunction

    // Union-find; isolated vertices count as their own component.
    function automatic coeffSumT refCoeff(edgeSetT g);
        int parent [numVertices];
        int k;
        int ra;
        int rb;
        int roots;
        for (int v = 0; v < numVertices; v++) parent[v] = v;
        k = 0;
        for (int i = 0; i < numVertices; i++) begin
            for (int j = i + 1; j < numVertices; j++) begin
                if (g[k]) begin
                    ra = i;
                    while (parent[ra] != ra) ra = parent[ra];
                    rb = j;
                    while (parent[rb] != rb) rb = parent[rb];
                    if (ra != rb) parent[rb] = ra;
                end
                k++;
            end
        end
        roots = 0;
        for (int v = 0; v < numVertices; v++) begin
            if (parent[v] == v) roots++;
        end
        return coeffSumT'(1) << roots;
    endfunction

    function automatic coeffSumT batchSum(edgeSetT top, int first, int n);
        coeffSumT sum;
        sum = '0;
        for (int i = 0; i < n; i++) sum = sum + refCoeff(top & ~stim[first + i]);
        return sum;
    endfunction

    // ==============================
    // Checks.
    // ==============================
    task automatic stopOnError();
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkSum(string testName, coeffSumT expected, coeffSumT actual);
        if (actual !== expected) begin
            $display("[FAIL] %s sum expected %0d actual %0d", testName, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkCount(string testName, itemCountT expected, itemCountT actual);
        if (actual !== expected) begin
            $display("[FAIL] %s count expected %0d actual %0d", testName, expected, actual);
            stopOnError();
        end
    endtask

    // ==============================
    // Drivers.
    // ==============================
    task automatic sendBot(edgeSetT top, edgeSetT b, logic last);
        logic accepted;
        sharedTop      = top;
        bot            = b;
        lastBotOfBatch = last;
        botValid       = 1'b1;
        accepted       = 1'b0;
        while (!accepted) begin
            accepted = botReady;  // Stable for the rest of the cycle.
            @(posedge clk);
            #1;
        end
    endtask

    task automatic driveBatch(edgeSetT top, int first, int n, logic markLast);
        for (int idx = 0; idx < n; idx++) begin
            sendBot(top, stim[first + idx], markLast && (idx == n - 1));
        end
        botValid = 1'b0;
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    task automatic checkResult(string testName, coeffSumT expSum, itemCountT expCount);
        while (!resultsValid) begin
            @(posedge clk);
            #1;
        end
        checkSum(testName, expSum, pcoeffSum);
        checkCount(testName, expCount, pcoeffCount);
        @(posedge clk);
        #1;
    endtask

    // ==============================
    // Directed tests.
    // ==============================
    task automatic fullyMaskedBatch();
        stim[0] = 15'h7fff;
        driveBatch(15'h7fff, 0, 1, 1'b1);
        checkResult("fullyMasked", coeffSumT'(64), itemCountT'(1));  // Six singletons.
    endtask

    task automatic completeGraphBatch();
        stim[0] = '0;
        driveBatch(15'h7fff, 0, 1, 1'b1);
        checkResult("completeGraph", coeffSumT'(2), itemCountT'(1));
    endtask

    task automatic handPickedGraphs();
        edgeSetT path;
        edgeSetT triangles;
        edgeSetT star;
        path      = edgeBit(0, 1) | edgeBit(1, 2) | edgeBit(2, 3) | edgeBit(3, 4) | edgeBit(4, 5);
        triangles = edgeBit(0, 1) | edgeBit(0, 2) | edgeBit(1, 2)
                  | edgeBit(3, 4) | edgeBit(3, 5) | edgeBit(4, 5);
        star      = edgeBit(0, 1) | edgeBit(0, 2) | edgeBit(0, 3);  // 4 and 5 isolated.
        stim[0] = 15'h7fff & ~path;
        stim[1] = 15'h7fff & ~triangles;
        stim[2] = 15'h7fff & ~star;
        driveBatch(15'h7fff, 0, 3, 1'b1);
        checkResult("handPicked", batchSum(15'h7fff, 0, 3), itemCountT'(3));
    endtask

    task automatic randomStreamBatch();
        edgeSetT top;
        top = randEdges();
        for (int i = 0; i < 40; i++) stim[i] = randEdges();
        driveBatch(top, 0, 40, 1'b1);
        checkResult("randomStream", batchSum(top, 0, 40), itemCountT'(40));
    endtask

    task automatic backToBackBatches();
        edgeSetT top;
        top = randEdges();
        for (int i = 0; i < 12; i++) stim[i] = randEdges();
        fork
            begin
                driveBatch(top, 0, 5, 1'b1);
                driveBatch(top, 5, 7, 1'b1);
            end
            begin
                checkResult("backToBackFirst", batchSum(top, 0, 5), itemCountT'(5));
                checkResult("backToBackSecond", batchSum(top, 5, 7), itemCountT'(7));
            end
        join
    endtask

    task automatic resetMidBatch();
        edgeSetT top;
        top = randEdges();
        for (int i = 0; i < 8; i++) stim[i] = randEdges();
        driveBatch(top, 0, 1, 1'b1);
        while (!resultsValid) begin
            @(posedge clk);
            #1;
        end
        applyReset();  // Lands on a result pulse.
        driveBatch(top, 1, 3, 1'b0);  // Batch left open.
        repeat (2) @(posedge clk);
        #1;
        applyReset();
        driveBatch(top, 4, 4, 1'b1);
        checkResult("resetMidBatch", batchSum(top, 4, 4), itemCountT'(4));
    endtask

    initial begin
        rstN           = 1'b0;
        sharedTop      = '0;
        bot            = '0;
        lastBotOfBatch = 1'b0;
        botValid       = 1'b0;
        applyReset();
        fullyMaskedBatch();
        completeGraphBatch();
        handPickedGraphs();
        randomStreamBatch();
        backToBackBatches();
        resetMidBatch();
        if (u_aggregatingPipeline.u_props.assertFailures == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d assertion failures", u_aggregatingPipeline.u_props.assertFailures);
            $display("tests failed");
            $fatal(1, "simulation stopped on assertion failures");
        end
    end

endmodule

`default_nettype wire

// ==== tb/aggregatingPipeline_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module aggregatingPipelineProps (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire graphPkg::edgeSetT   sharedTop,
    input  wire graphPkg::edgeSetT   bot,
    input  wire logic                lastBotOfBatch,
    input  wire logic                botValid,
    input  wire logic                botReady,
    input  wire logic                decValid,
    input  wire logic                decReady,
    input  wire graphPkg::edgeSetT   decGraph,
    input  wire graphPkg::compCountT decSingletonCount,
    input  wire logic                decLast,
    input  wire logic                resultsValid
);

    int assertFailures = 0;

    // A stalled bottom keeps its request and data.
    botHeld: assert property (@(posedge clk) disable iff (!rstN)
        botValid && !botReady |=> botValid && $stable(bot) && $stable(sharedTop)
            && $stable(lastBotOfBatch))
        else begin
            $error("bottom request changed before acceptance");
            assertFailures++;
        end

    decHeld: assert property (@(posedge clk) disable iff (!rstN)
        decValid && !decReady |=> decValid && $stable(decGraph)
            && $stable(decSingletonCount) && $stable(decLast))
        else begin
            $error("decode output changed under back-pressure");
            assertFailures++;
        end

    resultsLowInReset: assert property (@(posedge clk) !rstN |=> !resultsValid)
        else begin
            $error("resultsValid high during reset");
            assertFailures++;
        end

    resultsPulse: assert property (@(posedge clk) disable iff (!rstN)
        resultsValid |=> !resultsValid)
        else begin
            $error("resultsValid high for two cycles");
            assertFailures++;
        end

endmodule

bind aggregatingPipeline aggregatingPipelineProps u_props (
    .clk               (clk),
    .rstN              (rstN),
    .sharedTop         (sharedTop),
    .bot               (bot),
    .lastBotOfBatch    (lastBotOfBatch),
    .botValid          (botValid),
    .botReady          (botReady),
    .decValid          (decValid),
    .decReady          (decReady),
    .decGraph          (decGraph),
    .decSingletonCount (decSingletonCount),
    .decLast           (decLast),
    .resultsValid      (resultsValid)
);

`default_nettype wire

// ==== hw/aggregatingPipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module aggregatingPipeline (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire graphPkg::edgeSetT   sharedTop,
    input  wire graphPkg::edgeSetT   bot,
    input  wire logic                lastBotOfBatch,
    input  wire logic                botValid,
    output logic                     botReady,
    output logic                     resultsValid,
    output accumPkg::coeffSumT       pcoeffSum,
    output accumPkg::itemCountT      pcoeffCount
);

    import graphPkg::*;

    // Decode to execute.
    logic      decValid;
    logic      decReady;
    edgeSetT   decGraph;
    compCountT decSingletonCount;
    logic      decLast;

    // Execute to result.
    logic      cntValid;
    compCountT cntComponents;
    compCountT cntSingletonCount;
    logic      cntLast;

    edgeDecode u_decode (
        .clk               (clk),
        .rstN              (rstN),
        .sharedTop         (sharedTop),
        .bot               (bot),
        .inLast            (lastBotOfBatch),
        .inValid           (botValid),
        .inReady           (botReady),
        .outValid          (decValid),
        .outReady          (decReady),
        .outGraph          (decGraph),
        .outSingletonCount (decSingletonCount),
        .outLast           (decLast)
    );

    componentCounter u_execute (
        .clk               (clk),
        .rstN              (rstN),
        .inValid           (decValid),
        .inReady           (decReady),
        .inGraph           (decGraph),
        .inSingletonCount  (decSingletonCount),
        .inLast            (decLast),
        .outValid          (cntValid),
        .outComponents     (cntComponents),
        .outSingletonCount (cntSingletonCount),
        .outLast           (cntLast)
    );

    coeffAccumulator u_result (
        .clk              (clk),
        .rstN             (rstN),
        .inValid          (cntValid),
        .inComponents     (cntComponents),
        .inSingletonCount (cntSingletonCount),
        .inLast           (cntLast),
        .resultsValid     (resultsValid),
        .pcoeffSum        (pcoeffSum),
        .pcoeffCount      (pcoeffCount)
    );

endmodule

`default_nettype wire

// ==== hw/coeffAccumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffAccumulator (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                inValid,
    input  wire graphPkg::compCountT inComponents,
    input  wire graphPkg::compCountT inSingletonCount,
    input  wire logic                inLast,
    output logic                     resultsValid,
    output accumPkg::coeffSumT       pcoeffSum,
    output accumPkg::itemCountT      pcoeffCount
);

    import graphPkg::*;
    import accumPkg::*;

    compCountT exponent;
    coeffT     coeff;
    coeffSumT  runningSum;
    itemCountT runningCount;
    coeffSumT  nextSum;
    itemCountT nextCount;

    assign exponent  = inComponents + inSingletonCount;  // At most 6.
    assign coeff     = coeffT'(1) << exponent;
    assign nextSum   = runningSum + coeffSumT'(coeff);
    assign nextCount = runningCount + itemCountT'(1);   // Wraps.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            runningSum   <= '0;
            runningCount <= '0;
            resultsValid <= 1'b0;
            pcoeffSum    <= '0;
            pcoeffCount  <= '0;
        end else begin
            resultsValid <= inValid && inLast;
            if (inValid && inLast) begin
                // Report totals with this item, then restart.
                pcoeffSum    <= nextSum;
                pcoeffCount  <= nextCount;
                runningSum   <= '0;
                runningCount <= '0;
            end else if (inValid) begin
                runningSum   <= nextSum;
                runningCount <= nextCount;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/componentCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module componentCounter (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                inValid,
    output logic                     inReady,
    input  wire graphPkg::edgeSetT   inGraph,
    input  wire graphPkg::compCountT inSingletonCount,
    input  wire logic                inLast,
    output logic                     outValid,
    output graphPkg::compCountT      outComponents,
    output graphPkg::compCountT      outSingletonCount,
    output logic                     outLast
);

    import graphPkg::*;

    typedef enum logic [1:0] {
        idleS,
        propagateS,
        doneS
    } stateT;

    stateT     state;
    edgeSetT   graph;
    compCountT singletonCount;
    logic      last;
    vertexIdT  labels [numVertices];
    vertexIdT  nextLabels [numVertices];
    logic      changed;
    vertexSetT incident;
    compCountT roots;

    assign inReady  = (state == idleS);
    assign outValid = (state == doneS);
    assign incident = vertexIncidence(graph);

    // ==============================
    // One round of min-label propagation.
    // ==============================
    always_comb begin
        changed = 1'b0;
        for (int v = 0; v < numVertices; v++) begin
            nextLabels[v] = labels[v];
        end
        for (int i = 0; i < numVertices; i++) begin
            for (int j = i + 1; j < numVertices; j++) begin
                if (graph[edgeIndex(i, j)]) begin
                    if (labels[j] < nextLabels[i]) nextLabels[i] = labels[j];
                    if (labels[i] < nextLabels[j]) nextLabels[j] = labels[i];
                end
            end
        end
        for (int v = 0; v < numVertices; v++) begin
            if (nextLabels[v] != labels[v]) changed = 1'b1;
        end
    end

    // A component root keeps its own index; isolated vertices are excluded.
    always_comb begin
        roots = '0;
        for (int v = 0; v < numVertices; v++) begin
            if (incident[v] && labels[v] == vertexIdT'(v)) begin
                roots = roots + compCountT'(1);
            end
        end
    end

    // ==============================
    // Control FSM.
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idleS;
        end else begin
            case (state)
                idleS:      if (inValid) state <= propagateS;
                propagateS: if (!changed) state <= doneS;  // Converged.
                doneS:      state <= idleS;
                default:    state <= idleS;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idleS && inValid) begin
            graph          <= inGraph;
            singletonCount <= inSingletonCount;
            last           <= inLast;
            for (int v = 0; v < numVertices; v++) begin
                labels[v] <= vertexIdT'(v);
            end
        end else if (state == propagateS) begin
            labels <= nextLabels;
        end
    end

    assign outComponents     = roots;
    assign outSingletonCount = singletonCount;
    assign outLast           = last;

endmodule

`default_nettype wire

// ==== hw/edgeDecode.sv ====
`timescale 1ns/100ps
`default_nettype none

module edgeDecode (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire graphPkg::edgeSetT   sharedTop,
    input  wire graphPkg::edgeSetT   bot,
    input  wire logic                inLast,
    input  wire logic                inValid,
    output logic                     inReady,
    output logic                     outValid,
    input  wire logic                outReady,
    output graphPkg::edgeSetT        outGraph,
    output graphPkg::compCountT      outSingletonCount,
    output logic                     outLast
);

    import graphPkg::*;

    edgeSetT   maskedGraph;
    vertexSetT incident;
    compCountT singletonCount;
    logic      accept;

    // ==============================
    // Masking and singleton count.
    // ==============================
    assign maskedGraph = sharedTop & ~bot;
    assign incident    = vertexIncidence(maskedGraph);

    always_comb begin
        singletonCount = '0;
        for (int v = 0; v < numVertices; v++) begin
            if (!incident[v]) begin
                singletonCount = singletonCount + compCountT'(1);
            end
        end
    end

    // ==============================
    // Output register stage.
    // ==============================
    assign inReady = !outValid || outReady;  // Empty or draining.
    assign accept  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outGraph          <= maskedGraph;
            outSingletonCount <= singletonCount;
            outLast           <= inLast;
        end
    end

endmodule

`default_nettype wire

// ==== hw/accumPkg.sv ====
`default_nettype none

package accumPkg;

    localparam int coeffW     = 7;   // One-hot, 1 to 64.
    localparam int itemCountW = 8;
    localparam int coeffSumW  = 15;  // 255 items of 64.

    typedef logic [coeffW-1:0]     coeffT;
    typedef logic [itemCountW-1:0] itemCountT;
    typedef logic [coeffSumW-1:0]  coeffSumT;

endpackage

`default_nettype wire

// ==== hw/graphPkg.sv ====
`default_nettype none

package graphPkg;

    localparam int numVertices = 6;
    localparam int numEdges = numVertices * (numVertices - 1) / 2;

    typedef logic [numEdges-1:0]    edgeSetT;    // Bit k is edge k.
    typedef logic [numVertices-1:0] vertexSetT;
    typedef logic [2:0]             compCountT;  // 0 to 6.
    typedef logic [2:0]             vertexIdT;

    // Edge number of pair (a,b) in lexicographic order over a<b.
    function automatic int edgeIndex(int a, int b);
        int lo;
        int hi;
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        return lo * (2 * numVertices - 1 - lo) / 2 + (hi - lo - 1);
    endfunction

    // Vertices touched by at least one edge.
    function automatic vertexSetT vertexIncidence(edgeSetT g);
        vertexSetT inc;
        inc = '0;
        for (int i = 0; i < numVertices; i++) begin
            for (int j = i + 1; j < numVertices; j++) begin
                if (g[edgeIndex(i, j)]) begin
                    inc[i] = 1'b1;
                    inc[j] = 1'b1;
                end
            end
        end
        return inc;
    endfunction

endpackage

`default_nettype wire
